// File: packet_filter.f
+incdir+.
packet_filter_pkg.sv
packet_store.sv
rule_matcher.sv
packet_forwarder.sv
packet_filter_top.sv
packet_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f packet_filter.f --top-module packet_filter_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vpacket_filter_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Regression passed"; then
    exit 0
else
    exit 1
fi

// File: packet_filter_tb.sv
//------------------------------
// Random testbench for packet_filter_top
// Model in the testbench predicts every output beat
//------------------------------
`timescale 1ns/10ps
`include "packet_filter_config.svh"

module packet_filter_tb;
    import packet_filter_pkg::*;

    logic                          clk;
    logic                          reset;
    beat_t                         sn;
    logic                          sn_valid;
    rule_write_t                   rule_wr;
    out_beat_t                     out;
    logic                          out_valid;
    logic [`DROP_COUNT_WIDTH-1:0]  dropped_count;

    rule_t                         model_rules [`RULE_COUNT]; // Copy of the DUT rule table
    logic [`TAG_WIDTH-1:0]         model_tag;                 // Next tag to be used
    logic [`DROP_COUNT_WIDTH-1:0]  model_drops;
    logic [`BEAT_WIDTH-1:0]        pkt [40];                  // Packet being built
    out_beat_t                     expected [$];

    packet_filter_top packet_filter_top_inst (
        .clk           (clk),
        .reset         (reset),
        .sn            (sn),
        .sn_valid      (sn_valid),
        .rule_wr       (rule_wr),
        .out           (out),
        .out_valid     (out_valid),
        .dropped_count (dropped_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_beat(input out_beat_t got, input out_beat_t exp);
        if (got.data !== exp.data)
            abort_run($sformatf("error out.data got %h expected %h", got.data, exp.data));
        if (got.last !== exp.last)
            abort_run($sformatf("error out.last got %h expected %h", got.last, exp.last));
        if (got.tag !== exp.tag)
            abort_run($sformatf("error out.tag got %h expected %h", got.tag, exp.tag));
    endtask

    task automatic check_count(input logic [`DROP_COUNT_WIDTH-1:0] got,
                               input logic [`DROP_COUNT_WIDTH-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("error dropped_count got %h expected %h", got, exp));
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (expected.size() == 0)
                abort_run("output beat appeared with nothing expected");
            else
                check_beat(out, expected.pop_front());
        end
    end

    function automatic rule_t random_rule(input logic enable);
        rule_t r;
        r.enable = enable;
        r.index  = `BEAT_ADDR_WIDTH'($urandom % 8); // Early beats, so short packets can hit
        r.mask   = {$urandom, $urandom};
        r.value  = {$urandom, $urandom} & r.mask;
        return r;
    endfunction

    task automatic write_rule(input int slot, input rule_t r);
        @(posedge clk);
        rule_wr.valid <= 1'b1;
        rule_wr.slot  <= `RULE_ADDR_WIDTH'(slot);
        rule_wr.rule  <= r;
        @(posedge clk);
        rule_wr.valid <= 1'b0;
        model_rules[slot] = r;
    endtask

    task automatic make_packet();
        for (int i = 0; i < 40; i++)
            pkt[i] = {$urandom, $urandom};
    endtask

    // Bend one beat so the given rule matches, if the rule can see it at all
    task automatic force_hit(input int slot, input int len);
        rule_t r;
        r = model_rules[slot];
        if (r.enable && int'(r.index) < len)
            pkt[int'(r.index)] = r.value | (pkt[int'(r.index)] & ~r.mask);
    endtask

    task automatic send_packet(input int len, input logic dropped);
        int  kept;
        logic accept;
        out_beat_t b;
        kept   = (len > `MAX_BEATS) ? `MAX_BEATS : len;   // Store cuts long packets
        accept = 1'b0;
        for (int r = 0; r < `RULE_COUNT; r++) begin
            if (model_rules[r].enable && int'(model_rules[r].index) < kept
                && (pkt[int'(model_rules[r].index)] & model_rules[r].mask)
                   == model_rules[r].value)
                accept = 1'b1;
        end
        if (dropped) begin
            model_drops = model_drops + 1'b1;
        end else begin
            for (int i = 0; i < kept && accept; i++) begin
                b.data = pkt[i];
                b.last = (i == kept - 1);
                b.tag  = model_tag;
                expected.push_back(b);
            end
            model_tag = model_tag + 1'b1;               // Rejected packets count too
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            sn.data  <= pkt[i];
            sn.last  <= (i == len - 1);
            sn_valid <= 1'b1;
        end
        @(posedge clk);
        sn_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expected.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 200)
                abort_run("timed out waiting for expected output beats");
        end
        repeat (4) @(posedge clk); // Release and busy clear
    endtask

    initial begin
        int len;
        void'($urandom(32'hd75d));
        reset    = 1'b1;
        sn       = '0;
        sn_valid = 1'b0;
        rule_wr  = '0;
        model_tag   = '0;
        model_drops = '0;
        for (int i = 0; i < `RULE_COUNT; i++)
            model_rules[i] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // No rules yet, all rejected
        for (int n = 0; n < 3; n++) begin
            make_packet();
            send_packet(1 + $urandom % 40, 1'b0);
            wait_drain();
        end

        // Single matching rule, then misses mixed with hits
        write_rule(0, random_rule(1'b1));
        for (int n = 0; n < 7; n++) begin
            len = 8 + $urandom % 25;
            make_packet();
            if (n % 2 == 0)
                force_hit(0, len);
            send_packet(len, 1'b0);
            wait_drain();
        end

        // Oversized packet
        make_packet();
        force_hit(0, 40);
        send_packet(40, 1'b0);
        wait_drain();

        // Second packet lands while the first one still owns the store
        make_packet();
        force_hit(0, 10);
        send_packet(10, 1'b0);
        make_packet();
        force_hit(0, 8);        // Would come out if the store took it
        send_packet(8, 1'b1);
        wait_drain();
        check_count(dropped_count, model_drops);
        make_packet();
        force_hit(0, 12);
        send_packet(12, 1'b0);
        wait_drain();

        // Random traffic over a full table, slot 3 left off
        for (int s = 0; s < `RULE_COUNT; s++)
            write_rule(s, random_rule(s != 3));
        for (int n = 0; n < 20; n++) begin
            len = 1 + $urandom % 40;
            make_packet();
            if ($urandom % 2 == 1)
                force_hit($urandom % `RULE_COUNT, len);
            send_packet(len, 1'b0);
            wait_drain();
        end
        check_count(dropped_count, model_drops);

        $display("Regression passed");
        $finish;
    end

endmodule

// File: packet_filter_top.sv
//------------------------------
// Packet filter top level
// Snoop stream in, tagged accepted packets out
//------------------------------
`timescale 1ns/10ps
`include "packet_filter_config.svh"

module packet_filter_top (
    input  logic                              clk,
    input  logic                              reset,
    input  packet_filter_pkg::beat_t          sn,
    input  logic                              sn_valid,
    input  packet_filter_pkg::rule_write_t    rule_wr,
    output packet_filter_pkg::out_beat_t      out,
    output logic                              out_valid,
    output logic [`DROP_COUNT_WIDTH-1:0]      dropped_count
);
    import packet_filter_pkg::*;

    capture_t       capture;     // Store to matcher, same cycle as sn
    stored_packet_t done;        // Store to forwarder
    verdict_t       verdict;     // Matcher to forwarder
    store_read_t    rd;
    beat_t          rd_data;
    logic           pkt_release;

    // Store and matcher both watch the snoop stream
    packet_store packet_store_inst (
        .clk           (clk),
        .reset         (reset),
        .sn            (sn),
        .sn_valid      (sn_valid),
        .rd            (rd),
        .pkt_release   (pkt_release),
        .capture       (capture),
        .done          (done),
        .rd_data       (rd_data),
        .dropped_count (dropped_count)
    );

    rule_matcher rule_matcher_inst (
        .clk     (clk),
        .reset   (reset),
        .rule_wr (rule_wr),
        .capture (capture),
        .verdict (verdict)
    );

    // Joins the two results
    packet_forwarder packet_forwarder_inst (
        .clk         (clk),
        .reset       (reset),
        .done        (done),
        .verdict     (verdict),
        .rd_data     (rd_data),
        .rd          (rd),
        .pkt_release (pkt_release),
        .out         (out),
        .out_valid   (out_valid)
    );

endmodule

// File: packet_forwarder.sv
//------------------------------
// Plays out accepted packets from the store
// Tags every beat and frees the store
//------------------------------
`timescale 1ns/10ps
`include "packet_filter_config.svh"

module packet_forwarder (
    input  logic                                 clk,
    input  logic                                 reset,
    input  packet_filter_pkg::stored_packet_t    done,
    input  packet_filter_pkg::verdict_t          verdict,
    input  packet_filter_pkg::beat_t             rd_data,
    output packet_filter_pkg::store_read_t       rd,
    output logic                                 pkt_release,
    output packet_filter_pkg::out_beat_t         out,
    output logic                                 out_valid
);
    import packet_filter_pkg::*;

    store_read_t               rd_q;
    logic [`BEAT_ADDR_WIDTH:0] pkt_count;   // Beats to play, no reset
    logic [`BEAT_ADDR_WIDTH:0] last_addr;
    logic                      rd_final;
    logic                      pkt_go;
    logic                      out_valid_q; // Read valid delayed to match memory
    logic                      out_final_q;
    logic                      reject_q;
    logic [`TAG_WIDTH-1:0]     tag;

    assign pkt_go    = done.valid && verdict.valid && verdict.accept;
    assign last_addr = pkt_count - 1'b1;
    assign rd_final  = rd_q.valid && ({1'b0, rd_q.addr} == last_addr);
    assign rd        = rd_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q        <= '0;
            out_valid_q <= 1'b0;
            out_final_q <= 1'b0;
            reject_q    <= 1'b0;
            tag         <= '0;
        end else begin
            if (pkt_go) begin
                rd_q.valid <= 1'b1;
                rd_q.addr  <= '0;
            end else if (rd_final)
                rd_q.valid <= 1'b0;
            else if (rd_q.valid)
                rd_q.addr <= rd_q.addr + 1'b1;
            out_valid_q <= rd_q.valid;
            out_final_q <= rd_final;
            reject_q    <= done.valid && !verdict.accept; // Release right after done
            if (pkt_release)
                tag <= tag + 1'b1;  // Counts accepted and rejected alike
        end
    end

    always_ff @(posedge clk) begin
        if (done.valid)
            pkt_count <= done.count;
    end

    // Release goes with the final out beat of an accepted packet
    assign pkt_release = reject_q || (out_valid_q && out_final_q);
    assign out_valid   = out_valid_q;

    always_comb begin
        out.data = rd_data.data;
        out.last = out_final_q || rd_data.last; // Forced for truncated packets
        out.tag  = tag;
    end

    // Store and matcher must finish the same packet together
    a_done_verdict: assert property (@(posedge clk) disable iff (reset)
        done.valid == verdict.valid)
        else $error("done and verdict out of step");

endmodule

// File: rule_matcher.sv
//------------------------------
// Rule table checked against captured beats
// One verdict per captured packet
//------------------------------
`timescale 1ns/10ps
`include "packet_filter_config.svh"

module rule_matcher (
    input  logic                              clk,
    input  logic                              reset,
    input  packet_filter_pkg::rule_write_t    rule_wr,
    input  packet_filter_pkg::capture_t       capture,
    output packet_filter_pkg::verdict_t       verdict
);
    import packet_filter_pkg::*;

    rule_t                  rules [`RULE_COUNT];
    logic [`RULE_COUNT-1:0] hit;     // Rules already met earlier in this packet
    logic [`RULE_COUNT-1:0] hit_now; // Rules met by the current beat
    logic                   pkt_end;

    assign pkt_end = capture.valid && capture.last;

    // Each rule looks at exactly one beat position
    always_comb begin
        for (int i = 0; i < `RULE_COUNT; i++) begin
            hit_now[i] = capture.valid && rules[i].enable
                && (rules[i].index == capture.index)
                && ((capture.data & rules[i].mask) == rules[i].value);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RULE_COUNT; i++) begin
                rules[i] <= '0;                 // All slots disabled
            end
            hit     <= '0;
            verdict <= '0;
        end else begin
            if (rule_wr.valid)
                rules[rule_wr.slot] <= rule_wr.rule;
            // Lines up with done from the store
            verdict.valid  <= pkt_end;
            verdict.accept <= pkt_end && (|(hit | hit_now));
            if (pkt_end)
                hit <= '0;                      // Fresh start for next packet
            else
                hit <= hit | hit_now;
        end
    end

    // Slot field may be wider than the table
    a_rule_slot: assert property (@(posedge clk) disable iff (reset)
        rule_wr.valid |-> (int'(rule_wr.slot) < `RULE_COUNT))
        else $error("rule write to slot %0d", rule_wr.slot);

endmodule

// File: packet_store.sv
//------------------------------
// Packet memory fed by the snoop stream
// Holds one packet until the forwarder releases it
//------------------------------
`timescale 1ns/10ps
`include "packet_filter_config.svh"

module packet_store (
    input  logic                                 clk,
    input  logic                                 reset,
    input  packet_filter_pkg::beat_t             sn,
    input  logic                                 sn_valid,
    input  packet_filter_pkg::store_read_t       rd,
    input  logic                                 pkt_release,
    output packet_filter_pkg::capture_t          capture,
    output packet_filter_pkg::stored_packet_t    done,
    output packet_filter_pkg::beat_t             rd_data,
    output logic [`DROP_COUNT_WIDTH-1:0]         dropped_count
);
    import packet_filter_pkg::*;

    beat_t                       mem [`MAX_BEATS]; // Packet memory, no reset
    logic                        busy;             // Store holds or fills a packet
    logic                        rx_active;        // Between first and last beat on sn
    logic                        rx_keep;          // Current packet still goes to memory
    logic [`BEAT_ADDR_WIDTH-1:0] wr_idx;
    logic                        first_beat;
    logic                        start_keep;
    logic                        start_drop;
    logic                        at_limit;

    assign first_beat = sn_valid && !rx_active;
    assign start_keep = first_beat && !busy;
    assign start_drop = first_beat && busy;     // Whole packet is ignored
    assign at_limit   = (wr_idx == `BEAT_ADDR_WIDTH'(`MAX_BEATS - 1));

    // Straight from sn, no register on this path
    always_comb begin
        capture.valid = start_keep || (sn_valid && rx_active && rx_keep);
        capture.index = wr_idx;                 // Back at zero between packets
        capture.data  = sn.data;
        capture.last  = sn.last || at_limit;    // Truncated packets end here
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_active     <= 1'b0;
            rx_keep       <= 1'b0;
            wr_idx        <= '0;
            busy          <= 1'b0;
            done          <= '0;
            dropped_count <= '0;
        end else begin
            if (sn_valid) begin
                if (sn.last)
                    rx_active <= 1'b0;
                else if (first_beat)
                    rx_active <= 1'b1;
            end
            if (capture.valid) begin
                rx_keep <= !capture.last;       // Tail past the limit is skipped
                wr_idx  <= capture.last ? '0 : wr_idx + 1'b1;
            end
            if (start_keep)
                busy <= 1'b1;
            else if (pkt_release)
                busy <= 1'b0;
            done.valid <= capture.valid && capture.last;
            if (capture.valid && capture.last)
                done.count <= {1'b0, wr_idx} + 1'b1; // Held for the read check
            if (start_drop)
                dropped_count <= dropped_count + 1'b1;
        end
    end

    // Write port and one-cycle read port
    always_ff @(posedge clk) begin
        if (capture.valid)
            mem[wr_idx] <= sn;
        if (rd.valid)
            rd_data <= mem[rd.addr];
    end

    // Forwarder must stay inside the packet it was told about
    a_rd_in_packet: assert property (@(posedge clk) disable iff (reset)
        rd.valid |-> ({1'b0, rd.addr} < done.count))
        else $error("read past stored packet");

    a_release_busy: assert property (@(posedge clk) disable iff (reset)
        pkt_release |-> busy)
        else $error("release while store idle");

endmodule

// File: packet_filter_pkg.sv
//------------------------------
// Struct types passed between the filter blocks
//------------------------------
`include "packet_filter_config.svh"

package packet_filter_pkg;

    typedef struct packed {
        logic [`BEAT_WIDTH-1:0] data;
        logic                   last;
    } beat_t;

    // Beat taken into the store, seen by the matcher in the same cycle
    typedef struct packed {
        logic                        valid;
        logic [`BEAT_ADDR_WIDTH-1:0] index; // Beat number inside the packet
        logic [`BEAT_WIDTH-1:0]      data;
        logic                        last;  // Also set at the truncation point
    } capture_t;

    typedef struct packed {
        logic                        enable;
        logic [`BEAT_ADDR_WIDTH-1:0] index; // Which beat the rule looks at
        logic [`BEAT_WIDTH-1:0]      mask;
        logic [`BEAT_WIDTH-1:0]      value; // Compared against data & mask
    } rule_t;

    typedef struct packed {
        logic                        valid;
        logic [`RULE_ADDR_WIDTH-1:0] slot;
        rule_t                       rule;
    } rule_write_t;

    typedef struct packed {
        logic                      valid;
        logic [`BEAT_ADDR_WIDTH:0] count; // 1 to MAX_BEATS
    } stored_packet_t;

    typedef struct packed {
        logic valid;
        logic accept;
    } verdict_t;

    typedef struct packed {
        logic                        valid;
        logic [`BEAT_ADDR_WIDTH-1:0] addr;
    } store_read_t;

    typedef struct packed {
        logic [`BEAT_WIDTH-1:0] data;
        logic                   last;
        logic [`TAG_WIDTH-1:0]  tag;
    } out_beat_t;

endpackage

// File: packet_filter_config.svh
//------------------------------
// Sizes shared by the packet filter RTL
// Include wherever a width or depth is needed
//------------------------------
`ifndef PACKET_FILTER_CONFIG_SVH
`define PACKET_FILTER_CONFIG_SVH

// Stream beat, one 64-bit word
`define BEAT_WIDTH 64

// Packet memory, longer packets are cut here
`define MAX_BEATS 32
`define BEAT_ADDR_WIDTH 5

// Match rule table
`define RULE_COUNT 4
`define RULE_ADDR_WIDTH 2

`define TAG_WIDTH 8         // Reorder tag on every output beat
`define DROP_COUNT_WIDTH 16 // Wraps silently on overflow

`endif
